//--- dcache.f
verilog/dcachePkg.sv
verilog/dcacheController.sv
verilog/dcacheTagStore.sv
verilog/dcacheDataArray.sv
verilog/dcacheWordPath.sv
verilog/dcacheTop.sv
verification/dcacheCheck_assert.sv
verification/dcacheTb.sv

//--- Makefile
# Verilator flow for the data cache: lint, simulate, clean

VERILATOR ?= verilator
FILELIST ?= dcache.f
TB_TOP ?= dcacheTb
RTL_TOP ?= dcacheTop
BUILD_DIR ?= build
LOG ?= sim.log
VFLAGS ?= --timing --assert
FAIL_MSG ?= Simulation FAILED

RTL_SRCS := verilog/dcachePkg.sv verilog/dcacheController.sv verilog/dcacheTagStore.sv \
	verilog/dcacheDataArray.sv verilog/dcacheWordPath.sv verilog/dcacheTop.sv

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)

sim: build
	-$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "run ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/dcacheTb.sv
//######################################################################
// cache testbench: memory model, byte reference model, random traffic
//######################################################################

`timescale 1ns/1ns

module dcacheTb import dcachePkg::*; ();

        localparam int clockPeriod = 8;
        localparam int randomOps = 300;
        // worst miss: lookup, write-back and read at 7 cycles each, fill
        localparam int missCycles = 32;
        localparam int watchdogTime = (randomOps + 64) * missCycles * clockPeriod;

        logic clock;
        logic reset;
        logic rdEn;
        logic wrEn;
        addrT addr;
        byteMaskT byteMask;
        wordT wrData;
        wordT rdData;
        logic stall;
        logic memRen;
        logic memWen;
        blockAddrT memBlockAddr;
        blockT memWrData;
        blockT memRdData;
        logic memReadReady;
        logic memWriteDone;

        blockT memImage [1 << blockAddrWidth];
        logic [7:0] refBytes [1 << addrWidth];
        tagT tagPool [4] = '{8'h01, 8'h02, 8'h07, 8'h3c};
        logic [31:0] stimState;
        logic [31:0] delayState;
        int checks;
        int errors;
        int memReads;
        int memWrites;
        int delayLeft;
        bit memBusy;
        bit opLog [$];
        blockAddrT lastWriteBlock;

        dcacheTop i_dut (.*);

        always #(clockPeriod / 2) clock = ~clock;

        function automatic logic [31:0] lfsrNext(input logic [31:0] state);
                if (state[0]) begin
                        return (state >> 1) ^ 32'ha3000000;
                end
                return state >> 1;
        endfunction

        // one LFSR step per bit
        task automatic takeBits(inout logic [31:0] state, input int count,
                        output logic [31:0] value);
                value = '0;
                for (int i = 0; i < count; i++) begin
                        value = {value[30:0], state[0]};
                        state = lfsrNext(state);
                end
        endtask

        function automatic wordT modelWord(input addrT a);
                wordT word;
                for (int l = 0; l < wordBytes; l++) begin
                        word[l*8 +: 8] = refBytes[{a[15:2], l[1:0]}];
                end
                return word;
        endfunction

        function automatic blockT modelBlock(input blockAddrT blk);
                blockT block;
                for (int l = 0; l < blockBytes; l++) begin
                        block[l*8 +: 8] = refBytes[{blk, l[3:0]}];
                end
                return block;
        endfunction

        task automatic checkFlag(input bit cond, input string what);
                checks++;
                assert (cond) else begin
                        errors++;
                        $display("Fail %0t: %s", $time, what);
                end
        endtask

        task automatic reportTest(input string name, input int startChecks, input int startErrors);
                $display("test %s: %0d checks, %0d errors", name, checks - startChecks,
                        errors - startErrors);
        endtask

        // main memory, answers each request level after 0 to 7 cycles
        always @(posedge clock) begin
                logic [31:0] bits;
                memReadReady <= 1'b0;
                memWriteDone <= 1'b0;
                if (!memReadReady && !memWriteDone && (memRen || memWen)) begin
                        if (!memBusy) begin
                                takeBits(delayState, 3, bits);
                                delayLeft = int'(bits[2:0]);
                                memBusy = 1'b1;
                        end
                        if (delayLeft > 0) begin
                                delayLeft--;
                        end else if (memWen) begin
                                memBusy = 1'b0;
                                checks++;
                                assert (memWrData === modelBlock(memBlockAddr)) else begin
                                        errors++;
                                        $display("Fail %0t: write-back of block %h is %h, expected %h",
                                                $time, memBlockAddr, memWrData, modelBlock(memBlockAddr));
                                end
                                memImage[memBlockAddr] = memWrData;
                                lastWriteBlock = memBlockAddr;
                                memWrites++;
                                opLog.push_back(1'b1);
                                memWriteDone <= 1'b1;
                        end else begin
                                memBusy = 1'b0;
                                memRdData <= memImage[memBlockAddr];
                                memReads++;
                                opLog.push_back(1'b0);
                                memReadReady <= 1'b1;
                        end
                end
        end

        // one request, held until stall drops; reads checked against the model
        task automatic access(input bit isWrite, input addrT a, input byteMaskT mask,
                        input wordT data, output bit missed);
                @(posedge clock);
                rdEn <= !isWrite;
                wrEn <= isWrite;
                addr <= a;
                byteMask <= mask;
                wrData <= data;
                @(negedge clock);
                missed = stall;
                while (stall) begin
                        @(negedge clock);
                end
                if (isWrite) begin
                        for (int l = 0; l < wordBytes; l++) begin
                                if (mask[l]) begin
                                        refBytes[{a[15:2], l[1:0]}] = data[l*8 +: 8];
                                end
                        end
                end else begin
                        checks++;
                        assert (rdData === modelWord(a)) else begin
                                errors++;
                                $display("Fail %0t: read of %h returned %h, expected %h",
                                        $time, a, rdData, modelWord(a));
                        end
                end
        endtask

        initial begin
                int startChecks;
                int startErrors;
                int reads0;
                logic [31:0] bits;
                logic [31:0] data;
                bit missed;
                blockAddrT blk;
                clock = 1'b0;
                reset <= 1'b0;
                rdEn <= 1'b0;
                wrEn <= 1'b0;
                addr <= '0;
                byteMask <= '0;
                wrData <= '0;
                memRdData <= '0;
                memReadReady <= 1'b0;
                memWriteDone <= 1'b0;
                checks = 0;
                errors = 0;
                memReads = 0;
                memWrites = 0;
                memBusy = 1'b0;
                delayLeft = 0;
                stimState = 32'ha4ba;
                // delay stream runs ahead of the stimulus stream
                delayState = 32'ha4ba;
                takeBits(delayState, 16, bits);
                for (int b = 0; b < (1 << blockAddrWidth); b++) begin
                        for (int w = 0; w < blockWords; w++) begin
                                data = {4'h5, b[11:0], w[1:0], 14'h1a5};
                                memImage[b][w*wordWidth +: wordWidth] = data;
                                for (int l = 0; l < wordBytes; l++) begin
                                        refBytes[{b[11:0], w[1:0], l[1:0]}] = data[l*8 +: 8];
                                end
                        end
                end
                repeat (8) @(posedge clock);
                reset <= 1'b1;

                startChecks = checks;
                startErrors = errors;
                @(negedge clock);
                checkFlag(!stall && !memRen && !memWen, "stall or memory request high after reset");
                access(1'b0, 16'h0120, 4'h0, 32'h0, missed);
                checkFlag(missed, "first access did not miss");
                checkFlag(memReads == 1 && memWrites == 0, "first miss traffic is not one read");
                reportTest("after reset", startChecks, startErrors);

                startChecks = checks;
                startErrors = errors;
                reads0 = memReads;
                for (int i = 0; i < 3 * blockWords; i++) begin
                        access(1'b0, {12'h012, i[1:0], 2'b00}, 4'h0, 32'h0, missed);
                        checkFlag(!missed, "read of a filled block stalled");
                end
                checkFlag(memReads == reads0, "repeated reads caused memory traffic");
                reportTest("read hits", startChecks, startErrors);

                startChecks = checks;
                startErrors = errors;
                for (int i = 0; i < 8; i++) begin
                        takeBits(stimState, 6, bits);
                        takeBits(stimState, 32, data);
                        access(1'b1, {12'h012, bits[5:4], 2'b00}, bits[3:0], data, missed);
                        checkFlag(!missed, "write to a filled block stalled");
                end
                for (int w = 0; w < blockWords; w++) begin
                        access(1'b0, {12'h012, w[1:0], 2'b00}, 4'h0, 32'h0, missed);
                end
                reportTest("byte writes", startChecks, startErrors);

                startChecks = checks;
                startErrors = errors;
                opLog.delete();
                access(1'b0, 16'h0220, 4'h0, 32'h0, missed);
                checkFlag(opLog.size() == 2 && opLog[0] && !opLog[1],
                        "dirty eviction is not a write-back then a read");
                checkFlag(lastWriteBlock == 12'h012, "write-back went to the wrong block");
                opLog.delete();
                access(1'b0, 16'h0320, 4'h0, 32'h0, missed);
                checkFlag(opLog.size() == 1 && !opLog[0], "clean eviction is not a single read");
                reportTest("eviction", startChecks, startErrors);

                startChecks = checks;
                startErrors = errors;
                for (int i = 0; i < randomOps; i++) begin
                        takeBits(stimState, 13, bits);
                        takeBits(stimState, 32, data);
                        access(bits[4], {tagPool[bits[12:11]], bits[10:7], bits[6:5], 2'b00},
                                bits[3:0], data, missed);
                end
                // a tag outside the pool evicts every line
                for (int idx = 0; idx < lineCount; idx++) begin
                        access(1'b0, {8'hff, idx[3:0], 4'h0}, 4'h0, 32'h0, missed);
                end
                for (int t = 0; t < 4; t++) begin
                        for (int idx = 0; idx < lineCount; idx++) begin
                                blk = {tagPool[t], idx[3:0]};
                                checks++;
                                assert (memImage[blk] === modelBlock(blk)) else begin
                                        errors++;
                                        $display("Fail %0t: memory block %h is %h, expected %h",
                                                $time, blk, memImage[blk], modelBlock(blk));
                                end
                        end
                end
                reportTest("random mix", startChecks, startErrors);

                @(posedge clock);
                rdEn <= 1'b0;
                wrEn <= 1'b0;
                repeat (2) @(posedge clock);
                $display("checks %0d, errors %0d", checks, errors);
                if (errors == 0) begin
                        $display("Simulation PASSED");
                end else begin
                        $display("Simulation FAILED");
                end
                $finish;
        end

        initial begin
                #(watchdogTime);
                $display("watchdog expired before all tests finished");
                $display("Simulation FAILED");
                $finish;
        end

endmodule

//--- verification/dcacheCheck_assert.sv
//######################################################################
// protocol checks on the miss FSM, bound into the controller
//######################################################################

`timescale 1ns/1ns

module dcacheCheck import dcachePkg::*; (
        input  logic clock,
        input  logic reset,
        input  missStateT state,
        input  logic stall,
        input  logic memRen,
        input  logic memWen,
        input  logic fillEn
);

        // one memory request at a time
        reqExclusive: assert property (@(posedge clock) disable iff (!reset)
                        !(memRen && memWen))
                else $error("memRen and memWen are high together");

        // pipeline held during the whole miss
        stallOnMiss: assert property (@(posedge clock) disable iff (!reset)
                        (state != idle) |-> stall)
                else $error("stall is low outside the idle state");

        // fill is a single-cycle pulse
        fillSingle: assert property (@(posedge clock) disable iff (!reset)
                        fillEn |=> !fillEn)
                else $error("fill lasts longer than one cycle");

endmodule

bind dcacheController dcacheCheck i_check (
        .clock(clock),
        .reset(reset),
        .state(state),
        .stall(stall),
        .memRen(memRen),
        .memWen(memWen),
        .fillEn(fillEn)
);

//--- verilog/dcacheTop.sv
//######################################################################
// data cache top: miss FSM, tag store, data array and word path
//######################################################################

`timescale 1ns/1ns

module dcacheTop import dcachePkg::*; (
        input  logic clock,
        input  logic reset,
        // pipeline side
        input  logic rdEn,
        input  logic wrEn,
        input  addrT addr,
        input  byteMaskT byteMask,
        input  wordT wrData,
        output wordT rdData,
        output logic stall,
        // memory side
        output logic memRen,
        output logic memWen,
        output blockAddrT memBlockAddr,
        output blockT memWrData,
        input  blockT memRdData,
        input  logic memReadReady,
        input  logic memWriteDone
);

        tagT tag;
        indexT index;
        logic [wordSelWidth-1:0] wordSel;
        logic hit;
        logic victimDirty;
        tagT victimTag;
        logic fillEn;
        logic useVictimAddr;
        logic writeHit;
        blockMaskT blockMask;
        blockT blockWrData;
        blockT cacheBlock;

        // address fields
        assign tag = addr[offsetWidth+indexWidth +: tagWidth];
        assign index = addr[offsetWidth +: indexWidth];
        assign wordSel = addr[offsetWidth-wordSelWidth +: wordSelWidth];

        // stall is low only in idle with a hit or no request
        assign writeHit = wrEn & hit & ~stall;

        assign memBlockAddr = useVictimAddr ? {victimTag, index} : {tag, index};
        assign memWrData = cacheBlock;

        dcacheController i_controller (
                .clock(clock),
                .reset(reset),
                .rdEn(rdEn),
                .wrEn(wrEn),
                .hit(hit),
                .victimDirty(victimDirty),
                .memReadReady(memReadReady),
                .memWriteDone(memWriteDone),
                .stall(stall),
                .memRen(memRen),
                .memWen(memWen),
                .fillEn(fillEn),
                .useVictimAddr(useVictimAddr)
        );

        dcacheTagStore i_tagStore (
                .clock(clock),
                .reset(reset),
                .index(index),
                .tag(tag),
                .fillEn(fillEn),
                .writeHit(writeHit),
                .hit(hit),
                .victimDirty(victimDirty),
                .victimTag(victimTag)
        );

        dcacheDataArray i_dataArray (
                .clock(clock),
                .index(index),
                .writeEn(fillEn | writeHit),
                .byteEn(blockMask),
                .writeData(blockWrData),
                .readData(cacheBlock)
        );

        dcacheWordPath i_wordPath (
                .wordSel(wordSel),
                .byteMask(byteMask),
                .wrData(wrData),
                .memRdData(memRdData),
                .fillEn(fillEn),
                .cacheBlock(cacheBlock),
                .rdData(rdData),
                .blockMask(blockMask),
                .blockWrData(blockWrData)
        );

endmodule

//--- verilog/dcacheWordPath.sv
//######################################################################
// word select on read, block lane enables and data on write
//######################################################################

`timescale 1ns/1ns

module dcacheWordPath import dcachePkg::*; (
        input  logic [wordSelWidth-1:0] wordSel,
        input  byteMaskT byteMask,
        input  wordT wrData,
        input  blockT memRdData,
        input  logic fillEn,
        input  blockT cacheBlock,
        output wordT rdData,
        output blockMaskT blockMask,
        output blockT blockWrData
);

        blockMaskT wordMask;

        assign rdData = cacheBlock[wordSel*wordWidth +: wordWidth];

        // pipeline byte mask moved into the selected word's lanes
        always_comb begin
                wordMask = '0;
                for (int w = 0; w < blockWords; w++) begin
                        if (wordSel == w[wordSelWidth-1:0]) begin
                                wordMask[w*wordBytes +: wordBytes] = byteMask;
                        end
                end
        end

        // fill writes the whole block from memory
        always_comb begin
                if (fillEn) begin
                        blockMask = '1;
                        blockWrData = memRdData;
                end else begin
                        blockMask = wordMask;
                        // every word carries wrData, the mask picks the lanes
                        blockWrData = {blockWords{wrData}};
                end
        end

endmodule

//--- verilog/dcacheDataArray.sv
//######################################################################
// block data store, asynchronous read, byte-enabled write
//######################################################################

`timescale 1ns/1ns

module dcacheDataArray import dcachePkg::*; (
        input  logic clock,
        input  indexT index,
        input  logic writeEn,
        input  blockMaskT byteEn,
        input  blockT writeData,
        output blockT readData
);

        blockT blocks [lineCount];

        // one lane per byte of the block
        always_ff @(posedge clock) begin
                if (writeEn) begin
                        for (int lane = 0; lane < blockBytes; lane++) begin
                                if (byteEn[lane]) begin
                                        blocks[index][lane*8 +: 8] <= writeData[lane*8 +: 8];
                                end
                        end
                end
        end

        // combinational read so a hit returns data in the request cycle
        assign readData = blocks[index];

endmodule

//--- verilog/dcacheTagStore.sv
//######################################################################
// per-line valid, dirty and tag storage with hit detection
//######################################################################

`timescale 1ns/1ns

module dcacheTagStore import dcachePkg::*; (
        input  logic clock,
        input  logic reset,
        input  indexT index,
        input  tagT tag,
        input  logic fillEn,
        input  logic writeHit,
        output logic hit,
        output logic victimDirty,
        output tagT victimTag
);

        logic [lineCount-1:0] valid;
        logic [lineCount-1:0] dirty;
        tagT tags [lineCount];

        // line state bits
        always_ff @(posedge clock or negedge reset) begin
                if (!reset) begin
                        valid <= '0;
                        dirty <= '0;
                end else if (fillEn) begin
                        // freshly filled line is clean
                        valid[index] <= 1'b1;
                        dirty[index] <= 1'b0;
                end else if (writeHit) begin
                        dirty[index] <= 1'b1;
                end
        end

        always_ff @(posedge clock) begin
                if (fillEn) begin
                        tags[index] <= tag;
                end
        end

        // lookup of the indexed line
        assign hit = valid[index] && (tags[index] == tag);
        assign victimDirty = valid[index] & dirty[index];
        assign victimTag = tags[index];

endmodule

//--- verilog/dcacheController.sv
//######################################################################
// blocking miss FSM: stall, memory request and fill controls
//######################################################################

`timescale 1ns/1ns

module dcacheController import dcachePkg::*; (
        input  logic clock,
        input  logic reset,
        // pipeline request
        input  logic rdEn,
        input  logic wrEn,
        // tag store lookup
        input  logic hit,
        input  logic victimDirty,
        // memory handshake
        input  logic memReadReady,
        input  logic memWriteDone,
        output logic stall,
        output logic memRen,
        output logic memWen,
        output logic fillEn,
        output logic useVictimAddr
);

        missStateT state;
        missStateT nextState;
        logic request;

        assign request = rdEn | wrEn;

        always_ff @(posedge clock or negedge reset) begin
                if (!reset) begin
                        state <= idle;
                end else begin
                        state <= nextState;
                end
        end

        // next state
        always_comb begin
                nextState = state;
                case (state)
                        idle: begin
                                if (request && !hit) begin
                                        nextState = lookupMiss;
                                end
                        end
                        lookupMiss: begin
                                // dirty victim goes out before the new block comes in
                                if (victimDirty) begin
                                        nextState = writeBack;
                                end else begin
                                        nextState = memRead;
                                end
                        end
                        writeBack: begin
                                if (memWriteDone) begin
                                        nextState = memRead;
                                end
                        end
                        memRead: begin
                                if (memReadReady) begin
                                        nextState = fill;
                                end
                        end
                        fill: begin
                                nextState = idle;
                        end
                        default: begin
                                nextState = idle;
                        end
                endcase
        end

        // outputs from state; stall also from the lookup in idle
        always_comb begin
                stall = 1'b1;
                memRen = 1'b0;
                memWen = 1'b0;
                fillEn = 1'b0;
                useVictimAddr = 1'b0;
                case (state)
                        idle: begin
                                stall = request & ~hit;
                        end
                        lookupMiss: begin
                        end
                        writeBack: begin
                                memWen = 1'b1;
                                useVictimAddr = 1'b1;
                        end
                        memRead: begin
                                memRen = 1'b1;
                        end
                        fill: begin
                                fillEn = 1'b1;
                        end
                        default: begin
                        end
                endcase
        end

endmodule

//--- verilog/dcachePkg.sv
//######################################################################
// data cache widths, vector types and miss FSM states
//######################################################################

package dcachePkg;

        // address and data widths
        localparam int addrWidth = 16;
        localparam int wordWidth = 32;
        localparam int wordBytes = 4;

        // block geometry
        localparam int blockWords = 4;
        localparam int blockWidth = 128;
        localparam int blockBytes = 16;
        localparam int lineCount = 16;

        // address fields: tag 15..8, index 7..4, word 3..2, byte 1..0
        localparam int indexWidth = 4;
        localparam int offsetWidth = 4;
        localparam int tagWidth = 8;
        localparam int wordSelWidth = 2;
        localparam int blockAddrWidth = 12;

        typedef logic [addrWidth-1:0] addrT;
        typedef logic [wordWidth-1:0] wordT;
        typedef logic [wordBytes-1:0] byteMaskT;
        typedef logic [blockWidth-1:0] blockT;
        typedef logic [blockBytes-1:0] blockMaskT;
        typedef logic [tagWidth-1:0] tagT;
        typedef logic [indexWidth-1:0] indexT;
        typedef logic [blockAddrWidth-1:0] blockAddrT;

        typedef enum logic [2:0] {
                idle,
                lookupMiss,
                writeBack,
                memRead,
                fill
        } missStateT;

endpackage
